/* hdl/drbg_pkg.sv */
package drbg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and value types
    ////////////////////////////////////////////////////////////////////////////

    localparam int WORD_W = 64;
    localparam int BUS_W  = 32;
    localparam int ADDR_W = 3;

    // K, V, seed halves joined, tag
    typedef logic [WORD_W-1:0] word_t;
    // wishbone data word
    typedef logic [BUS_W-1:0]  bus_t;
    // register word address
    typedef logic [ADDR_W-1:0] reg_addr_t;
    // prf round index
    typedef logic [2:0]        round_t;

    // controller steps, init walks MIX_*, next walks GEN_V/UPD_*
    typedef enum logic [2:0] {
        IDLE,
        MIX_K,
        MIX_V,
        GEN_V,
        UPD_K,
        UPD_V
    } drbg_state_e;

    // source of the prf message
    typedef enum logic [1:0] {
        SEL_V_XOR_SEED,
        SEL_V,
        SEL_V_INV
    } prf_sel_e;

    ////////////////////////////////////////////////////////////////////////////
    // prf constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int    PRF_ROUNDS = 8;
    localparam int    ROT_AMT    = 13;
    localparam word_t K_INIT     = '0;
    localparam word_t V_INIT     = 64'h0101_0101_0101_0101;

    // one constant per round, indexed by round_t
    localparam word_t ROUND_CONST [PRF_ROUNDS] = '{
        64'h428a_2f98_d728_ae22,
        64'h7137_4491_23ef_65cd,
        64'hb5c0_fbcf_ec4d_3b2f,
        64'he9b5_dba5_8189_dbbc,
        64'h3956_c25b_f348_b538,
        64'h59f1_11f1_b605_d019,
        64'h923f_82a4_af19_4f9b,
        64'hab1c_5ed5_da6d_8118
    };

    ////////////////////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////////////////////

    localparam reg_addr_t ADDR_CTRL     = 3'd0;
    localparam reg_addr_t ADDR_STATUS   = 3'd1;
    localparam reg_addr_t ADDR_ENT_LO   = 3'd2;
    localparam reg_addr_t ADDR_ENT_HI   = 3'd3;
    localparam reg_addr_t ADDR_NONCE_LO = 3'd4;
    localparam reg_addr_t ADDR_NONCE_HI = 3'd5;
    localparam reg_addr_t ADDR_TAG_LO   = 3'd6;
    localparam reg_addr_t ADDR_TAG_HI   = 3'd7;

    // ctrl write bits
    localparam int CTRL_INIT_BIT    = 0;
    localparam int CTRL_NEXT_BIT    = 1;
    localparam int CTRL_ZEROIZE_BIT = 2;

    // status read bits
    localparam int STAT_READY_BIT = 0;
    localparam int STAT_VALID_BIT = 1;

endpackage

/* hdl/prf_if.sv */
`timescale 1ns/1ns

// handshake between controller and prf datapath
interface prf_if;
    import drbg_pkg::*;

    // one-cycle request, only taken while core idle
    logic  start;
    // key must hold for the whole evaluation
    word_t key;
    // message, sampled on start only
    word_t msg;
    // one-cycle completion pulse
    logic  done;
    // valid from done until the next start
    word_t result;

    modport ctrl (
        output start,
        output key,
        output msg,
        input  done,
        input  result
    );

    modport core (
        input  start,
        input  key,
        input  msg,
        output done,
        output result
    );

endinterface

/* hdl/round_counter.sv */
`timescale 1ns/1ns

module round_counter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  logic             enable,
    output drbg_pkg::round_t round,
    output logic             last
);
    import drbg_pkg::*;

    round_t count;

    // final round of one evaluation
    assign last  = (count == round_t'(PRF_ROUNDS - 1));
    assign round = count;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (clear)
        begin
            // restart at round zero on a new evaluation
            count <= '0;
        end
        else if (enable)
        begin
            // wrap back after the last round
            if (last)
            begin
                count <= '0;
            end
            else
            begin
                count <= count + round_t'(1);
            end
        end
    end

endmodule

/* hdl/prf_core.sv */
`timescale 1ns/1ns

module prf_core (
    input logic clk,
    input logic rst_n,
    input logic zeroize,
    prf_if.core prf
);
    import drbg_pkg::*;

    logic   busy;
    logic   done_q;
    logic   accept;
    logic   last;
    round_t round;
    word_t  state;
    word_t  sum;
    word_t  rot;
    word_t  round_out;

    ////////////////////////////////////////////////////////////////////////////
    // round function
    ////////////////////////////////////////////////////////////////////////////

    // start only counts while idle
    assign accept = prf.start && !busy;

    // add key, rotate left, mix in the round constant
    assign sum       = state + prf.key;
    assign rot       = (sum << ROT_AMT) | (sum >> (WORD_W - ROT_AMT));
    assign round_out = rot ^ ROUND_CONST[round];

    round_counter u_round_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (accept || zeroize),
        .enable (busy),
        .round  (round),
        .last   (last)
    );

    ////////////////////////////////////////////////////////////////////////////
    // state register and handshake
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy   <= 1'b0;
            done_q <= 1'b0;
            state  <= '0;
        end
        else if (zeroize)
        begin
            // abort, drop any partial value
            busy   <= 1'b0;
            done_q <= 1'b0;
            state  <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (accept)
            begin
                // whitening of the message with the key
                state <= prf.msg ^ prf.key;
                busy  <= 1'b1;
            end
            else if (busy)
            begin
                state <= round_out;
                // 8 rounds then a single done pulse
                if (last)
                begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // state holds after the last round, so result stays valid
    assign prf.done   = done_q;
    assign prf.result = state;

endmodule

/* hdl/drbg_state.sv */
`timescale 1ns/1ns

module drbg_state (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            zeroize,
    input  logic            clear_kv,
    input  logic            load_k,
    input  logic            load_v,
    input  logic            capture_tag,
    input  drbg_pkg::word_t result,
    output drbg_pkg::word_t k,
    output drbg_pkg::word_t v,
    output drbg_pkg::word_t tag,
    output logic            tag_valid,
    output logic            instantiated
);
    import drbg_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // key and chain value
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            k            <= '0;
            v            <= '0;
            instantiated <= 1'b0;
        end
        else if (zeroize)
        begin
            k            <= '0;
            v            <= '0;
            instantiated <= 1'b0;
        end
        else if (clear_kv)
        begin
            // start constants ahead of the seed mix
            k            <= K_INIT;
            v            <= V_INIT;
            instantiated <= 1'b1;
        end
        else
        begin
            if (load_k)
            begin
                k <= result;
            end
            if (load_v)
            begin
                v <= result;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output tag
    ////////////////////////////////////////////////////////////////////////////

    // capture_tag spans the whole generate step
    // first cycle drops valid, the closing load_v takes the new tag
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tag       <= '0;
            tag_valid <= 1'b0;
        end
        else if (zeroize)
        begin
            tag       <= '0;
            tag_valid <= 1'b0;
        end
        else if (clear_kv)
        begin
            // a new init voids the old tag
            tag_valid <= 1'b0;
        end
        else if (capture_tag)
        begin
            if (load_v)
            begin
                tag       <= result;
                tag_valid <= 1'b1;
            end
            else
            begin
                tag_valid <= 1'b0;
            end
        end
    end

endmodule

/* hdl/drbg_ctrl.sv */
`timescale 1ns/1ns

module drbg_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            init_cmd,
    input  logic            next_cmd,
    input  logic            zeroize,
    input  drbg_pkg::word_t seed,
    input  logic            instantiated,
    input  drbg_pkg::word_t k,
    input  drbg_pkg::word_t v,
    prf_if.ctrl             prf,
    output logic            load_k,
    output logic            load_v,
    output logic            clear_kv,
    output logic            capture_tag,
    output logic            ready
);
    import drbg_pkg::*;

    drbg_state_e state;
    prf_sel_e    sel;
    logic        start_q;

    ////////////////////////////////////////////////////////////////////////////
    // message mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (state)
            MIX_K:   sel = SEL_V_XOR_SEED;
            UPD_K:   sel = SEL_V_INV;
            default: sel = SEL_V;
        endcase
    end

    always_comb
    begin
        case (sel)
            SEL_V_XOR_SEED: prf.msg = v ^ seed;
            SEL_V_INV:      prf.msg = ~v;
            default:        prf.msg = v;
        endcase
    end

    // K stays put during an evaluation, loads only on done
    assign prf.key   = k;
    assign prf.start = start_q;

    // register strobes, all tied to the done pulse
    assign load_k      = prf.done && (state == MIX_K || state == UPD_K);
    assign load_v      = prf.done && (state == MIX_V || state == GEN_V || state == UPD_V);
    assign capture_tag = (state == GEN_V);
    assign clear_kv    = (state == IDLE) && init_cmd && !zeroize;
    assign ready       = (state == IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= IDLE;
            start_q <= 1'b0;
        end
        else if (zeroize)
        begin
            state   <= IDLE;
            start_q <= 1'b0;
        end
        else
        begin
            // start is a pulse on entry to each prf step
            start_q <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (init_cmd)
                    begin
                        state   <= MIX_K;
                        start_q <= 1'b1;
                    end
                    else if (next_cmd && instantiated)
                    begin
                        state   <= GEN_V;
                        start_q <= 1'b1;
                    end
                end
                MIX_K:
                begin
                    if (prf.done)
                    begin
                        state   <= MIX_V;
                        start_q <= 1'b1;
                    end
                end
                GEN_V:
                begin
                    if (prf.done)
                    begin
                        state   <= UPD_K;
                        start_q <= 1'b1;
                    end
                end
                UPD_K:
                begin
                    if (prf.done)
                    begin
                        state   <= UPD_V;
                        start_q <= 1'b1;
                    end
                end
                // last V update of init or next
                MIX_V, UPD_V:
                begin
                    if (prf.done)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/wb_regs.sv */
`timescale 1ns/1ns

module wb_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  drbg_pkg::reg_addr_t  adr,
    input  drbg_pkg::bus_t       dat_w,
    input  logic [3:0]           sel,
    output drbg_pkg::bus_t       dat_r,
    output logic                 ack,
    output logic                 init_cmd,
    output logic                 next_cmd,
    output logic                 zeroize,
    output drbg_pkg::word_t      seed,
    input  logic                 ready,
    input  logic                 tag_valid,
    input  drbg_pkg::word_t      tag
);
    import drbg_pkg::*;

    logic req;
    logic wr_en;
    logic ctrl_wr;
    bus_t ent_lo;
    bus_t ent_hi;
    bus_t nonce_lo;
    bus_t nonce_hi;
    bus_t rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // bus handshake
    ////////////////////////////////////////////////////////////////////////////

    // new access, ack forces a gap cycle afterwards
    assign req = cyc && stb && !ack;
    // sel only as all-or-nothing
    assign wr_en   = req && we && (|sel);
    assign ctrl_wr = wr_en && (adr == ADDR_CTRL);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // seed registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ent_lo   <= '0;
            ent_hi   <= '0;
            nonce_lo <= '0;
            nonce_hi <= '0;
        end
        else if (wr_en)
        begin
            case (adr)
                ADDR_ENT_LO:   ent_lo   <= dat_w;
                ADDR_ENT_HI:   ent_hi   <= dat_w;
                ADDR_NONCE_LO: nonce_lo <= dat_w;
                ADDR_NONCE_HI: nonce_hi <= dat_w;
                default:       ;
            endcase
        end
    end

    assign seed = {ent_hi, ent_lo} ^ {nonce_hi, nonce_lo};

    // command pulses line up with ack
    // init with next in one write runs neither
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            init_cmd <= 1'b0;
            next_cmd <= 1'b0;
            zeroize  <= 1'b0;
        end
        else
        begin
            init_cmd <= ctrl_wr && dat_w[CTRL_INIT_BIT] && !dat_w[CTRL_NEXT_BIT];
            next_cmd <= ctrl_wr && dat_w[CTRL_NEXT_BIT] && !dat_w[CTRL_INIT_BIT];
            zeroize  <= ctrl_wr && dat_w[CTRL_ZEROIZE_BIT];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        rd_data = '0;
        case (adr)
            ADDR_STATUS:
            begin
                rd_data[STAT_READY_BIT] = ready;
                rd_data[STAT_VALID_BIT] = tag_valid;
            end
            ADDR_ENT_LO:   rd_data = ent_lo;
            ADDR_ENT_HI:   rd_data = ent_hi;
            ADDR_NONCE_LO: rd_data = nonce_lo;
            ADDR_NONCE_HI: rd_data = nonce_hi;
            ADDR_TAG_LO:   rd_data = tag[BUS_W-1:0];
            ADDR_TAG_HI:   rd_data = tag[WORD_W-1:BUS_W];
            // ctrl is write only
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dat_r <= '0;
        end
        else if (req && !we)
        begin
            dat_r <= rd_data;
        end
    end

endmodule

/* hdl/drbg_top.sv */
`timescale 1ns/1ns

module drbg_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  drbg_pkg::reg_addr_t adr,
    input  drbg_pkg::bus_t      dat_w,
    input  logic [3:0]          sel,
    output drbg_pkg::bus_t      dat_r,
    output logic                ack,
    output logic                ready,
    output logic                tag_valid,
    output drbg_pkg::word_t     tag
);
    import drbg_pkg::*;

    logic  init_cmd;
    logic  next_cmd;
    logic  zeroize;
    logic  instantiated;
    logic  load_k;
    logic  load_v;
    logic  clear_kv;
    logic  capture_tag;
    word_t seed;
    word_t k;
    word_t v;

    prf_if u_prf_if ();

    // bus side, command decode
    wb_regs u_wb_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .sel       (sel),
        .dat_r     (dat_r),
        .ack       (ack),
        .init_cmd  (init_cmd),
        .next_cmd  (next_cmd),
        .zeroize   (zeroize),
        .seed      (seed),
        .ready     (ready),
        .tag_valid (tag_valid),
        .tag       (tag)
    );

    drbg_ctrl u_drbg_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_cmd     (init_cmd),
        .next_cmd     (next_cmd),
        .zeroize      (zeroize),
        .seed         (seed),
        .instantiated (instantiated),
        .k            (k),
        .v            (v),
        .prf          (u_prf_if.ctrl),
        .load_k       (load_k),
        .load_v       (load_v),
        .clear_kv     (clear_kv),
        .capture_tag  (capture_tag),
        .ready        (ready)
    );

    drbg_state u_drbg_state (
        .clk          (clk),
        .rst_n        (rst_n),
        .zeroize      (zeroize),
        .clear_kv     (clear_kv),
        .load_k       (load_k),
        .load_v       (load_v),
        .capture_tag  (capture_tag),
        .result       (u_prf_if.result),
        .k            (k),
        .v            (v),
        .tag          (tag),
        .tag_valid    (tag_valid),
        .instantiated (instantiated)
    );

    prf_core u_prf_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .prf     (u_prf_if.core)
    );

endmodule

/* sim/drbg_assert.sv */
`timescale 1ns/1ns

module drbg_assert (
    input logic            clk,
    input logic            rst_n,
    input logic            cyc,
    input logic            stb,
    input logic            ack,
    input logic            ready,
    input logic            start,
    input logic            zeroize,
    input logic            tag_valid,
    input logic            instantiated,
    input drbg_pkg::word_t tag
);

    ////////////////////////////////////////////////////////////////////////////
    // output tag
    ////////////////////////////////////////////////////////////////////////////

    // tag only moves while valid is low
    a_tag_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tag_valid && $past(tag_valid) |-> $stable(tag))
        else $error("tag changed while tag_valid was high");

    // no tag out of an uninstantiated generator
    a_valid_needs_inst: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tag_valid) |-> instantiated)
        else $error("tag_valid rose while not instantiated");

    ////////////////////////////////////////////////////////////////////////////
    // bus and sequencing
    ////////////////////////////////////////////////////////////////////////////

    // ack only inside an active cycle
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> cyc && stb)
        else $error("ack high without cyc and stb");

    // a prf step keeps the controller busy, unless zeroize cuts it
    a_busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        start && !zeroize |=> !ready)
        else $error("ready high in the cycle after a prf start");

endmodule

bind drbg_top drbg_assert u_drbg_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .cyc          (cyc),
    .stb          (stb),
    .ack          (ack),
    .ready        (ready),
    .start        (u_prf_if.start),
    .zeroize      (zeroize),
    .tag_valid    (tag_valid),
    .instantiated (instantiated),
    .tag          (tag)
);

/* sim/drbg_tb.sv */
`timescale 1ns/1ns

module drbg_tb;
    import drbg_pkg::*;

    // bus ack within a few cycles, a next takes about 33
    localparam int ACK_TIMEOUT   = 16;
    localparam int READY_TIMEOUT = 200;

    logic       clk;
    logic       rst_n;
    logic       cyc;
    logic       stb;
    logic       we;
    reg_addr_t  adr;
    bus_t       dat_w;
    logic [3:0] sel;
    bus_t       dat_r;
    logic       ack;
    logic       ready;
    logic       tag_valid;
    word_t      tag;

    // reference model state
    word_t m_k;
    word_t m_v;
    word_t m_tag;
    logic  m_valid;
    logic  m_inst;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          tests;
    int          test_start_errors;

    drbg_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .sel       (sel),
        .dat_r     (dat_r),
        .ack       (ack),
        .ready     (ready),
        .tag_valid (tag_valid),
        .tag       (tag)
    );

    // 8 ns period
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus source and reference model
    ////////////////////////////////////////////////////////////////////////////

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    task automatic rand_bus(output bus_t w);
        for (int i = 0; i < 32; i++)
        begin
            w[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // keyed add-rotate-xor function
    function automatic word_t prf_model(input word_t key, input word_t msg);
        word_t s;
        word_t sum;
        s = msg ^ key;
        for (int r = 0; r < PRF_ROUNDS; r++)
        begin
            sum = s + key;
            s   = ((sum << ROT_AMT) | (sum >> (64 - ROT_AMT))) ^ ROUND_CONST[r];
        end
        return s;
    endfunction

    // instantiate, tag itself stays, only valid drops
    task automatic model_init(input word_t seed);
        m_k     = K_INIT;
        m_v     = V_INIT;
        m_k     = prf_model(m_k, m_v ^ seed);
        m_v     = prf_model(m_k, m_v);
        m_inst  = 1'b1;
        m_valid = 1'b0;
    endtask

    // generate, dropped without an instantiate
    task automatic model_next();
        if (m_inst)
        begin
            m_v     = prf_model(m_k, m_v);
            m_tag   = m_v;
            m_valid = 1'b1;
            m_k     = prf_model(m_k, ~m_v);
            m_v     = prf_model(m_k, m_v);
        end
    endtask

    task automatic model_zeroize();
        m_k     = '0;
        m_v     = '0;
        m_tag   = '0;
        m_valid = 1'b0;
        m_inst  = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus access and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("mismatch %s: got %h, expected %h", what, got, exp);
            errors++;
        end
    endtask

    // hold cyc and stb through the ack cycle, release one edge later
    task automatic wb_write(input reg_addr_t a, input bus_t d, input logic [3:0] s);
        int n;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        sel   = s;
        n     = 0;
        @(negedge clk);
        while (!ack && n < ACK_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!ack)
        begin
            $display("no ack for write to address %0d", a);
            errors++;
        end
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        sel = 4'h0;
    endtask

    task automatic wb_read(input reg_addr_t a, output bus_t d);
        int n;
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        sel = 4'hf;
        n   = 0;
        @(negedge clk);
        while (!ack && n < ACK_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!ack)
        begin
            $display("no ack for read from address %0d", a);
            errors++;
        end
        d = dat_r;
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        sel = 4'h0;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < READY_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (!ready)
        begin
            $display("ready did not return within %0d cycles", READY_TIMEOUT);
            errors++;
        end
    endtask

    // ctrl bits: 0 init, 1 next, 2 zeroize
    task automatic issue_cmd(input bus_t bits);
        wb_write(ADDR_CTRL, bits, 4'hf);
    endtask

    // fresh entropy and nonce, returns their xor
    task automatic load_seed(output word_t seed);
        bus_t el;
        bus_t eh;
        bus_t nl;
        bus_t nh;
        rand_bus(el);
        rand_bus(eh);
        rand_bus(nl);
        rand_bus(nh);
        wb_write(ADDR_ENT_LO, el, 4'hf);
        wb_write(ADDR_ENT_HI, eh, 4'hf);
        wb_write(ADDR_NONCE_LO, nl, 4'hf);
        wb_write(ADDR_NONCE_HI, nh, 4'hf);
        seed = {eh, el} ^ {nh, nl};
    endtask

    // status, both tag halves and the tag ports against the model
    task automatic check_outputs();
        bus_t st;
        bus_t lo;
        bus_t hi;
        wb_read(ADDR_STATUS, st);
        check_word("status", st, {m_valid, 1'b1});
        wb_read(ADDR_TAG_LO, lo);
        wb_read(ADDR_TAG_HI, hi);
        check_word("tag registers", {hi, lo}, m_tag);
        check_word("tag", tag, m_tag);
        check_word("tag_valid", tag_valid, m_valid);
        check_word("ready", ready, 1);
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        bus_t d;
        begin_test();
        check_outputs();
        // ctrl is write only
        wb_read(ADDR_CTRL, d);
        check_word("ctrl read", d, 0);
        end_test("reset_values");
    endtask

    task automatic test_register_readback();
        bus_t      wr [4];
        bus_t      rd;
        reg_addr_t a;
        begin_test();
        for (int i = 0; i < 4; i++)
        begin
            a = reg_addr_t'(ADDR_ENT_LO + i);
            rand_bus(wr[i]);
            wb_write(a, wr[i], 4'hf);
        end
        for (int i = 0; i < 4; i++)
        begin
            a = reg_addr_t'(ADDR_ENT_LO + i);
            wb_read(a, rd);
            check_word($sformatf("reg %0d readback", a), rd, wr[i]);
        end
        // write with no byte lane set
        for (int i = 0; i < 4; i++)
        begin
            a = reg_addr_t'(ADDR_ENT_LO + i);
            wb_write(a, ~wr[i], 4'h0);
            wb_read(a, rd);
            check_word($sformatf("reg %0d after sel zero", a), rd, wr[i]);
        end
        end_test("register_readback");
    endtask

    task automatic test_illegal_commands();
        word_t seed;
        begin_test();
        // next with nothing instantiated
        issue_cmd(32'h2);
        wait_ready();
        check_outputs();
        load_seed(seed);
        // init together with next
        issue_cmd(32'h3);
        // a started sequence would already hold ready low here
        check_word("ready after init with next", ready, 1);
        wait_ready();
        check_outputs();
        // next while init still runs
        issue_cmd(32'h1);
        if (!ready)
        begin
            issue_cmd(32'h2);
        end
        else
        begin
            $display("init did not start, ready still high");
            errors++;
        end
        wait_ready();
        model_init(seed);
        check_outputs();
        // init while next runs
        issue_cmd(32'h2);
        issue_cmd(32'h1);
        wait_ready();
        model_next();
        check_outputs();
        issue_cmd(32'h2);
        wait_ready();
        model_next();
        check_outputs();
        end_test("illegal_commands");
    endtask

    task automatic test_instantiate_generate();
        word_t seed;
        begin_test();
        load_seed(seed);
        issue_cmd(32'h1);
        wait_ready();
        model_init(seed);
        check_outputs();
        for (int i = 0; i < 4; i++)
        begin
            issue_cmd(32'h2);
            wait_ready();
            model_next();
            check_outputs();
        end
        end_test("instantiate_generate");
    endtask

    task automatic test_zeroize();
        word_t seed;
        begin_test();
        issue_cmd(32'h2);
        // land the zeroize inside the next sequence
        repeat (6) @(negedge clk);
        if (ready)
        begin
            $display("next finished before zeroize was issued");
            errors++;
        end
        issue_cmd(32'h4);
        check_word("ready after zeroize", ready, 1);
        wait_ready();
        model_zeroize();
        check_outputs();
        // dropped, nothing instantiated
        issue_cmd(32'h2);
        wait_ready();
        check_outputs();
        load_seed(seed);
        issue_cmd(32'h1);
        wait_ready();
        model_init(seed);
        check_outputs();
        for (int i = 0; i < 2; i++)
        begin
            issue_cmd(32'h2);
            wait_ready();
            model_next();
            check_outputs();
        end
        end_test("zeroize");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        rst_n  = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        sel    = 4'h0;
        lfsr   = 32'hcc47_6150;
        errors = 0;
        checks = 0;
        tests  = 0;
        model_zeroize();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset_values();
        test_register_readback();
        test_illegal_commands();
        test_instantiate_generate();
        test_zeroize();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* filelist.f */
hdl/drbg_pkg.sv
hdl/prf_if.sv
hdl/round_counter.sv
hdl/prf_core.sv
hdl/drbg_state.sv
hdl/drbg_ctrl.sv
hdl/wb_regs.sv
hdl/drbg_top.sv
sim/drbg_assert.sv
sim/drbg_tb.sv
